//--- include/pcie_msi_consts.svh
// MSI limits for the UltraScale PCIe core; only function 0 is served, at most 32 vectors
`ifndef PCIE_MSI_CONSTS_SVH
`define PCIE_MSI_CONSTS_SVH

// width of the core's MSI vector fields (int, pending status, data)
`define MSI_VEC_MAX 32

// interrupt request lines wired by default
`define MSI_PORTS_DEFAULT 4

// cfg_interrupt_msi_enable bit of function 0
// mmenable holds one 3-bit code per function, so this also picks the code
`define MSI_FUNC0_BIT 0

`endif

//--- verilog/msi_vec_pkg.sv
// vector types sized for the full 32-vector MSI field; unused upper vectors are left at zero
`default_nettype none

`include "pcie_msi_consts.svh"

package msi_vec_pkg;

    // one bit per MSI vector
    // used for the host mask, the deliverable set, pending and clear strobes
    typedef logic [`MSI_VEC_MAX-1:0] vec_mask_t;

    // vector number within the MSI field
    typedef logic [$clog2(`MSI_VEC_MAX)-1:0] vec_idx_t;

endpackage

`default_nettype wire

//--- verilog/msi_cfg_pkg.sv
// MSI configuration and issuer types; codes 6 and 7 of mme are reserved by PCIe
`default_nettype none

package msi_cfg_pkg;

    // multiple message enable of one function
    // code n allows vectors 0 .. 2**n-1
    typedef logic [2:0] mme_t;

    // issuer FSM
    // issue_gap is the single idle cycle that follows each response
    typedef enum logic [1:0] {
        issue_idle      = 2'd0,
        issue_wait_resp = 2'd1,
        issue_gap       = 2'd2
    } issue_state_t;

endpackage

`default_nettype wire

//--- verilog/msi_mask_track.sv
// function 0 only; vec_enable lags mask_update, msi_enable and mmenable by one cycle
`default_nettype none

`include "pcie_msi_consts.svh"

module msi_mask_track
    import msi_vec_pkg::*;
    import msi_cfg_pkg::*;
#(
    parameter int PORTS = `MSI_PORTS_DEFAULT
)
(
    input  wire logic          pcie_clk,
    input  wire logic          pcie_rst,

    input  wire logic [3:0]    cfg_interrupt_msi_enable,
    input  wire logic [11:0]   cfg_interrupt_msi_mmenable,
    input  wire logic          cfg_interrupt_msi_mask_update,
    input  wire logic [31:0]   cfg_interrupt_msi_data,

    output vec_mask_t          vec_enable
);

vec_mask_t mask_reg;
vec_mask_t mask_next;
vec_mask_t enable_next;
mme_t      mme_f0;
logic      func0_en;

always_comb begin
    // the core presents the new mask on msi_data with the update pulse
    mask_next = cfg_interrupt_msi_mask_update ? vec_mask_t'(cfg_interrupt_msi_data) : mask_reg;

    func0_en = cfg_interrupt_msi_enable[`MSI_FUNC0_BIT];
    mme_f0 = cfg_interrupt_msi_mmenable[`MSI_FUNC0_BIT*3 +: 3];

    for (int i = 0; i < `MSI_VEC_MAX; i++) begin
        // reserved mme codes give a limit above 32, so every vector passes
        enable_next[i] = func0_en
            && (i < PORTS)
            && (i < (32'd1 << mme_f0))
            && !mask_next[i];
    end
end

always_ff @(posedge pcie_clk) begin
    mask_reg <= mask_next;
    vec_enable <= enable_next;

    if (pcie_rst) begin
        // everything masked until the host writes the mask
        mask_reg <= '1;
        vec_enable <= '0;
    end
end

endmodule

`default_nettype wire

//--- verilog/msi_vector_pending.sv
// rising-edge capture only; a level held high yields one interrupt per assertion
`default_nettype none

module msi_vector_pending (
    input  wire logic  pcie_clk,
    input  wire logic  pcie_rst,

    input  wire logic  irq,
    input  wire logic  clear,

    output logic       pending
);

logic irq_q;
logic irq_rise;

assign irq_rise = irq && !irq_q;

// previous level is tracked through reset too,
// so a line already high when reset drops gives no edge
always_ff @(posedge pcie_clk) begin
    irq_q <= irq;
end

always_ff @(posedge pcie_clk) begin
    // a new edge wins over a clear in the same cycle
    if (irq_rise) begin
        pending <= 1'b1;
    end else if (clear) begin
        pending <= 1'b0;
    end

    if (pcie_rst) begin
        pending <= 1'b0;
    end
end

endmodule

`default_nettype wire

//--- verilog/msi_issue_arb.sv
// one MSI outstanding at a time; the core may hold off sent/fail for any number of cycles
`default_nettype none

`include "pcie_msi_consts.svh"

module msi_issue_arb
    import msi_vec_pkg::*;
    import msi_cfg_pkg::*;
(
    input  wire logic                      pcie_clk,
    input  wire logic                      pcie_rst,

    input  wire vec_mask_t                 vec_pending,
    input  wire vec_mask_t                 vec_enable,

    input  wire logic                      cfg_interrupt_msi_sent,
    input  wire logic                      cfg_interrupt_msi_fail,
    output logic [`MSI_VEC_MAX-1:0]        cfg_interrupt_msi_int,

    output vec_mask_t                      vec_clear
);

issue_state_t state;

// next vector to look at first
vec_idx_t rr_ptr;

// vector waiting on the core's response
vec_idx_t issued_idx;

vec_mask_t vec_avail;
logic      cand_found;
vec_idx_t  cand_idx;

assign vec_avail = vec_pending & vec_enable;

always_comb begin
    vec_idx_t scan_idx;

    cand_found = 1'b0;
    cand_idx = '0;

    // first available vector at or after the pointer, wrapping at 32
    for (int j = 0; j < `MSI_VEC_MAX; j++) begin
        scan_idx = rr_ptr + vec_idx_t'(j);
        if (!cand_found && vec_avail[scan_idx]) begin
            cand_found = 1'b1;
            cand_idx = scan_idx;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    // int and clear are single-cycle strobes
    cfg_interrupt_msi_int <= '0;
    vec_clear <= '0;

    case (state)
        issue_idle: begin
            if (cand_found) begin
                cfg_interrupt_msi_int <= vec_mask_t'(1) << cand_idx;
                issued_idx <= cand_idx;
                // pointer moves on even if this one later fails
                rr_ptr <= cand_idx + 1'b1;
                state <= issue_wait_resp;
            end
        end
        issue_wait_resp: begin
            if (cfg_interrupt_msi_sent) begin
                vec_clear <= vec_mask_t'(1) << issued_idx;
                state <= issue_gap;
            end else if (cfg_interrupt_msi_fail) begin
                // left pending, picked up again on its next turn
                state <= issue_gap;
            end
        end
        default: begin
            // gap cycle lets the clear reach the pending latch first
            state <= issue_idle;
        end
    endcase

    if (pcie_rst) begin
        state <= issue_idle;
        rr_ptr <= '0;
        cfg_interrupt_msi_int <= '0;
        vec_clear <= '0;
    end
end

endmodule

`default_nettype wire

//--- verilog/cndm_pcie_msi.sv
// MSI path to the UltraScale core for PORTS = 1..32 request lines; function 0 only
`default_nettype none

`include "pcie_msi_consts.svh"

module cndm_pcie_msi
    import msi_vec_pkg::*;
#(
    parameter int PORTS = `MSI_PORTS_DEFAULT
)
(
    input  wire logic                   pcie_clk,
    input  wire logic                   pcie_rst,

    // per-port interrupt requests, edge sensitive
    input  wire logic [PORTS-1:0]       irq,

    input  wire logic [3:0]             cfg_interrupt_msi_enable,
    input  wire logic [11:0]            cfg_interrupt_msi_mmenable,
    input  wire logic                   cfg_interrupt_msi_mask_update,
    input  wire logic [31:0]            cfg_interrupt_msi_data,

    input  wire logic                   cfg_interrupt_msi_sent,
    input  wire logic                   cfg_interrupt_msi_fail,
    output logic [`MSI_VEC_MAX-1:0]     cfg_interrupt_msi_int,
    output logic [`MSI_VEC_MAX-1:0]     cfg_interrupt_msi_pending_status
);

vec_mask_t        vec_enable;
vec_mask_t        vec_pending;
vec_mask_t        vec_clear;
logic [PORTS-1:0] port_pending;

msi_mask_track #(
    .PORTS(PORTS)
)
mask_track_inst (
    .pcie_clk(pcie_clk),
    .pcie_rst(pcie_rst),
    .cfg_interrupt_msi_enable(cfg_interrupt_msi_enable),
    .cfg_interrupt_msi_mmenable(cfg_interrupt_msi_mmenable),
    .cfg_interrupt_msi_mask_update(cfg_interrupt_msi_mask_update),
    .cfg_interrupt_msi_data(cfg_interrupt_msi_data),
    .vec_enable(vec_enable)
);

for (genvar i = 0; i < PORTS; i++) begin : gen_pending
    msi_vector_pending pending_inst (
        .pcie_clk(pcie_clk),
        .pcie_rst(pcie_rst),
        .irq(irq[i]),
        .clear(vec_clear[i]),
        .pending(port_pending[i])
    );
end

// vectors above PORTS never pend
assign vec_pending = vec_mask_t'(port_pending);
assign cfg_interrupt_msi_pending_status = vec_pending;

msi_issue_arb issue_arb_inst (
    .pcie_clk(pcie_clk),
    .pcie_rst(pcie_rst),
    .vec_pending(vec_pending),
    .vec_enable(vec_enable),
    .cfg_interrupt_msi_sent(cfg_interrupt_msi_sent),
    .cfg_interrupt_msi_fail(cfg_interrupt_msi_fail),
    .cfg_interrupt_msi_int(cfg_interrupt_msi_int),
    .vec_clear(vec_clear)
);

endmodule

`default_nettype wire

//--- verification/cndm_pcie_msi_props.sv
// handshake checks for the MSI issuer; assumes the core never answers without an issued int
`default_nettype none

`include "pcie_msi_consts.svh"

module cndm_pcie_msi_props
    import msi_vec_pkg::*;
(
    input  wire logic                      pcie_clk,
    input  wire logic                      pcie_rst,
    input  wire vec_mask_t                 vec_enable,
    input  wire vec_mask_t                 vec_clear,
    input  wire logic                      cfg_interrupt_msi_sent,
    input  wire logic                      cfg_interrupt_msi_fail,
    input  wire logic [`MSI_VEC_MAX-1:0]   cfg_interrupt_msi_int
);

timeunit 1ns;
timeprecision 1ps;

// set by an int pulse, dropped by the core's answer
logic outstanding;

always_ff @(posedge pcie_clk) begin
    if (cfg_interrupt_msi_int != '0) begin
        outstanding <= 1'b1;
    end
    if (cfg_interrupt_msi_sent || cfg_interrupt_msi_fail) begin
        outstanding <= 1'b0;
    end

    if (pcie_rst) begin
        outstanding <= 1'b0;
    end
end

int_onehot: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    $onehot0(cfg_interrupt_msi_int))
    else $error("cfg_interrupt_msi_int has more than one bit set");

int_while_waiting: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    outstanding |-> (cfg_interrupt_msi_int == '0))
    else $error("int raised while a response was still outstanding");

// int is registered from the previous cycle's enable set
int_enabled: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    (cfg_interrupt_msi_int != '0) |-> ((cfg_interrupt_msi_int & ~$past(vec_enable)) == '0))
    else $error("int issued for a vector that was not enabled");

clear_after_sent: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    (vec_clear != '0) |-> $past(cfg_interrupt_msi_sent))
    else $error("vec_clear strobed without sent in the cycle before");

endmodule

bind msi_issue_arb cndm_pcie_msi_props props_inst (
    .pcie_clk(pcie_clk),
    .pcie_rst(pcie_rst),
    .vec_enable(vec_enable),
    .vec_clear(vec_clear),
    .cfg_interrupt_msi_sent(cfg_interrupt_msi_sent),
    .cfg_interrupt_msi_fail(cfg_interrupt_msi_fail),
    .cfg_interrupt_msi_int(cfg_interrupt_msi_int)
);

`default_nettype wire

//--- verification/cndm_pcie_msi_tb.sv
// directed tests at PORTS = 4 with a model of the PCIe core answering after 1 to 4 cycles
`default_nettype none

`include "pcie_msi_consts.svh"

module cndm_pcie_msi_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int PORTS = `MSI_PORTS_DEFAULT;
localparam int CLK_PERIOD = 40;
localparam int DRIVE_DELAY = 2;
localparam int TEST_COUNT = 6;
localparam int TEST_CYCLES_MAX = 300;
localparam int MARGIN_CYCLES = 1200;
localparam int TIMEOUT_CYCLES = TEST_COUNT * TEST_CYCLES_MAX + MARGIN_CYCLES;
localparam int ISSUE_WAIT_LIMIT = 40;
localparam int QUIET_CYCLES = 20;

logic                     pcie_clk;
logic                     pcie_rst;
logic [PORTS-1:0]         irq;
logic [3:0]               cfg_interrupt_msi_enable;
logic [11:0]              cfg_interrupt_msi_mmenable;
logic                     cfg_interrupt_msi_mask_update;
logic [31:0]              cfg_interrupt_msi_data;
logic                     cfg_interrupt_msi_sent;
logic                     cfg_interrupt_msi_fail;
logic [`MSI_VEC_MAX-1:0]  cfg_interrupt_msi_int;
logic [`MSI_VEC_MAX-1:0]  cfg_interrupt_msi_pending_status;

int          errors = 0;
int          checks = 0;
int          cycle_count = 0;
int unsigned lcg_state = 32'd27037;

// responder bookkeeping
logic [31:0] int_log[$];
int          fail_requests = 0;
int          fail_served = 0;

cndm_pcie_msi #(
    .PORTS(PORTS)
)
cndm_pcie_msi_inst (
    .pcie_clk(pcie_clk),
    .pcie_rst(pcie_rst),
    .irq(irq),
    .cfg_interrupt_msi_enable(cfg_interrupt_msi_enable),
    .cfg_interrupt_msi_mmenable(cfg_interrupt_msi_mmenable),
    .cfg_interrupt_msi_mask_update(cfg_interrupt_msi_mask_update),
    .cfg_interrupt_msi_data(cfg_interrupt_msi_data),
    .cfg_interrupt_msi_sent(cfg_interrupt_msi_sent),
    .cfg_interrupt_msi_fail(cfg_interrupt_msi_fail),
    .cfg_interrupt_msi_int(cfg_interrupt_msi_int),
    .cfg_interrupt_msi_pending_status(cfg_interrupt_msi_pending_status)
);

initial begin : clock_gen
    pcie_clk = 1'b0;
    forever begin
        #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;
    end
end

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

// all inputs change a little after the rising edge
task automatic next_edge();
    @(posedge pcie_clk);
    #(DRIVE_DELAY);
endtask

task automatic apply_reset();
    pcie_rst = 1'b1;
    repeat (3) next_edge();
    pcie_rst = 1'b0;
endtask

task automatic check_equal(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
        errors++;
    end
endtask

// host writes enable, multiple-message code and mask; enable set is valid on return
task automatic set_msi_config(input logic [3:0] enable, input logic [11:0] mme,
                              input logic [31:0] mask);
    cfg_interrupt_msi_enable = enable;
    cfg_interrupt_msi_mmenable = mme;
    cfg_interrupt_msi_data = mask;
    cfg_interrupt_msi_mask_update = 1'b1;
    next_edge();
    cfg_interrupt_msi_mask_update = 1'b0;
    cfg_interrupt_msi_data = '0;
endtask

task automatic wait_for_int(input string test, output logic [31:0] seen);
    int n;
    seen = '0;
    n = 0;
    while (seen == '0 && n < ISSUE_WAIT_LIMIT) begin
        next_edge();
        seen = cfg_interrupt_msi_int;
        n++;
    end
    checks++;
    assert (seen != '0) else begin
        $display("%s: no MSI was issued within %0d cycles", test, ISSUE_WAIT_LIMIT);
        errors++;
    end
endtask

task automatic wait_pending(input string test, input logic [31:0] expected);
    int n;
    n = 0;
    while (cfg_interrupt_msi_pending_status !== expected && n < ISSUE_WAIT_LIMIT) begin
        next_edge();
        n++;
    end
    checks++;
    assert (cfg_interrupt_msi_pending_status === expected) else begin
        $display("%s: pending status did not settle to %h within %0d cycles",
                 test, expected, ISSUE_WAIT_LIMIT);
        errors++;
    end
endtask

task automatic test_reset_state();
    repeat (10) begin
        next_edge();
        check_equal("reset_state", "int", 32'h0, cfg_interrupt_msi_int);
        check_equal("reset_state", "pending", 32'h0, cfg_interrupt_msi_pending_status);
    end
endtask

task automatic test_single_vector();
    int log_base;
    logic [31:0] seen;
    set_msi_config(4'b0001, 12'h002, 32'h0);
    log_base = int_log.size();
    irq[1] = 1'b1;
    wait_for_int("single_vector", seen);
    check_equal("single_vector", "int", 32'h2, seen);
    check_equal("single_vector", "pending at issue", 32'h2, cfg_interrupt_msi_pending_status);
    wait_pending("single_vector", 32'h0);
    // line stays high, no second edge
    repeat (QUIET_CYCLES) next_edge();
    check_equal("single_vector", "int count", 32'd1, 32'(int_log.size() - log_base));
    irq[1] = 1'b0;
    next_edge();
endtask

task automatic test_mask();
    int log_base;
    logic [31:0] seen;
    set_msi_config(4'b0001, 12'h002, 32'h4);
    log_base = int_log.size();
    irq[2] = 1'b1;
    repeat (QUIET_CYCLES) next_edge();
    check_equal("mask", "pending while masked", 32'h4, cfg_interrupt_msi_pending_status);
    check_equal("mask", "int count while masked", 32'd0, 32'(int_log.size() - log_base));
    set_msi_config(4'b0001, 12'h002, 32'h0);
    wait_for_int("mask", seen);
    check_equal("mask", "int", 32'h4, seen);
    wait_pending("mask", 32'h0);
    check_equal("mask", "int count", 32'd1, 32'(int_log.size() - log_base));
    irq[2] = 1'b0;
    next_edge();
endtask

task automatic test_mme_limit();
    int log_base;
    logic [31:0] seen;
    // code 1 allows vectors 0 and 1 only
    set_msi_config(4'b0001, 12'h001, 32'h0);
    log_base = int_log.size();
    irq[3] = 1'b1;
    repeat (QUIET_CYCLES) next_edge();
    check_equal("mme_limit", "pending above limit", 32'h8, cfg_interrupt_msi_pending_status);
    check_equal("mme_limit", "int count above limit", 32'd0, 32'(int_log.size() - log_base));
    cfg_interrupt_msi_mmenable = 12'h002;
    wait_for_int("mme_limit", seen);
    check_equal("mme_limit", "int", 32'h8, seen);
    wait_pending("mme_limit", 32'h0);
    check_equal("mme_limit", "int count", 32'd1, 32'(int_log.size() - log_base));
    irq[3] = 1'b0;
    next_edge();
endtask

task automatic test_fail_retry();
    int log_base;
    logic [31:0] seen;
    log_base = int_log.size();
    fail_requests++;
    irq[0] = 1'b1;
    wait_for_int("fail_retry", seen);
    check_equal("fail_retry", "first int", 32'h1, seen);
    wait_for_int("fail_retry", seen);
    check_equal("fail_retry", "retry int", 32'h1, seen);
    check_equal("fail_retry", "pending at retry", 32'h1, cfg_interrupt_msi_pending_status);
    wait_pending("fail_retry", 32'h0);
    check_equal("fail_retry", "int count", 32'd2, 32'(int_log.size() - log_base));
    irq[0] = 1'b0;
    next_edge();
endtask

task automatic test_all_at_once();
    int log_base;
    // fresh reset puts the round-robin pointer back at vector 0
    apply_reset();
    set_msi_config(4'b0001, 12'h002, 32'h0);
    log_base = int_log.size();
    irq = '1;
    next_edge();
    wait_pending("all_at_once", 32'h0);
    repeat (4) next_edge();
    check_equal("all_at_once", "int count", 32'(PORTS), 32'(int_log.size() - log_base));
    for (int k = 0; k < PORTS; k++) begin
        check_equal("all_at_once", "issue order", 32'd1 << k, int_log[log_base + k]);
    end
    irq = '0;
    next_edge();
endtask

// PCIe core model, answers each int pulse with sent or a requested fail
initial begin : core_responder
    int unsigned delay;
    cfg_interrupt_msi_sent = 1'b0;
    cfg_interrupt_msi_fail = 1'b0;
    forever begin
        @(posedge pcie_clk);
        if (cfg_interrupt_msi_int != '0) begin
            int_log.push_back(cfg_interrupt_msi_int);
            delay = 1 + lcg_next() % 4;
            repeat (delay - 1) @(posedge pcie_clk);
            #(DRIVE_DELAY);
            if (fail_served < fail_requests) begin
                cfg_interrupt_msi_fail = 1'b1;
                fail_served++;
            end else begin
                cfg_interrupt_msi_sent = 1'b1;
            end
            @(posedge pcie_clk);
            #(DRIVE_DELAY);
            cfg_interrupt_msi_sent = 1'b0;
            cfg_interrupt_msi_fail = 1'b0;
        end
    end
end

initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge pcie_clk);
        cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("summary: %0d checks, %0d errors", checks, errors);
    $display("TEST FAIL");
    $finish;
end

initial begin : main_sequence
    pcie_rst = 1'b1;
    irq = '0;
    cfg_interrupt_msi_enable = 4'h0;
    cfg_interrupt_msi_mmenable = 12'h000;
    cfg_interrupt_msi_mask_update = 1'b0;
    cfg_interrupt_msi_data = 32'h0;

    apply_reset();
    test_reset_state();
    test_single_vector();
    test_mask();
    test_mme_limit();
    test_fail_retry();
    test_all_at_once();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
verilog/msi_vec_pkg.sv
verilog/msi_cfg_pkg.sv
verilog/msi_mask_track.sv
verilog/msi_vector_pending.sv
verilog/msi_issue_arb.sv
verilog/cndm_pcie_msi.sv
verification/cndm_pcie_msi_props.sv
verification/cndm_pcie_msi_tb.sv

//--- Makefile
TOP = cndm_pcie_msi_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f include/pcie_msi_consts.svh verilog/*.sv verification/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module $(TOP)

# the simulation passes only if the pass message shows up in its output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
